// File: include/mult_macros.svh
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// architecture widths
`define ARCH_WIDTH   32 // one word, operand size
`define ARCH_WIDTH_H 16 // half word
`define ARCH_WIDTH_D 64 // double word, full product

// simd lane tiles for the pp masks
`define TILE_8  8  // dot8 lanes, four per word
`define TILE_16 16 // dot16 lanes, two per word

// walks one index over a width
// usage: `IT_P(i, W) stmt;
`define IT_P(idx, width) for (int idx = 0; idx < (width); idx++)

`endif

// File: logic/mult_pkg.sv
`default_nettype none

`include "mult_macros.svh"

package mult_pkg;

    // op codes, msb marks a simd op
    typedef enum logic [2:0] {
        MULT_OP_MUL    = 3'b000, // low word
        MULT_OP_MULH   = 3'b001, // high word, s x s
        MULT_OP_MULHSU = 3'b010, // high word, s x u
        MULT_OP_MULHU  = 3'b011, // high word, u x u
        MULT_OP_DOT16  = 3'b100, // 2 lanes of 16x16
        MULT_OP_DOT8   = 3'b101  // 4 lanes of 8x8
    } mult_op_t;

    // single word
    typedef logic [`ARCH_WIDTH-1:0] simd_t;

    // double word, flat or as two halves
    typedef union packed {
        logic [`ARCH_WIDTH_D-1:0] d;
        simd_t [1:0]              w; // w[1] is the high word
    } simd_d_t;

    // same shape as the core's pipe control
    typedef struct packed {
        logic en;    // load stage
        logic flush; // back to reset value, wins over en
    } stage_ctrl_t;

endpackage

`default_nettype wire

// File: logic/mult_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "mult_macros.svh"

// pp matrix and side data into the reduction
interface pp_bus_if import mult_pkg::*; ();
    simd_d_t [`ARCH_WIDTH-1:0] rows;   // aligned pp rows
    simd_d_t                   corr;   // bw correction constant
    mult_op_t                  op;
    simd_t                     a;      // needed later for mulhsu
    logic                      b_sign; // msb of b

    modport src (output rows, corr, op, a, b_sign);
    modport dst (input  rows, corr, op, a, b_sign);
endinterface

// reduced sum plus registered side data to the result select
interface sum_bus_if import mult_pkg::*; ();
    simd_d_t  tree_sum; // cpa of the final tree
    simd_d_t  corr;
    mult_op_t op;
    simd_t    a;
    logic     b_sign;

    modport src (output tree_sum, corr, op, a, b_sign);
    modport dst (input  tree_sum, corr, op, a, b_sign);
endinterface

`default_nettype wire

// File: logic/mult_pp_gen.sv
`default_nettype none
`timescale 1ns/1ps

`include "mult_macros.svh"

module mult_pp_gen import mult_pkg::*; (
    input  mult_op_t i_op,
    input  simd_t    i_a,
    input  simd_t    i_b,
    pp_bus_if.src    o_pp
);

    localparam int unsigned W   = `ARCH_WIDTH;
    localparam int unsigned W_D = `ARCH_WIDTH_D;

    // baugh-wooley flip for lane size sz
    // set on the lane's sign row or sign col, never on both
    function automatic logic bw_flip(input int i, input int j, input int sz);
        logic last_i;
        logic last_j;
        last_i = ((i % sz) == (sz - 1));
        last_j = ((j % sz) == (sz - 1));
        return last_i ^ last_j; // sign x sign stays as is
    endfunction

    logic op_dot16;
    logic op_dot8;
    logic op_simd;

    assign op_dot16 = (i_op == MULT_OP_DOT16);
    assign op_dot8  = (i_op == MULT_OP_DOT8);
    assign op_simd  = i_op[2];

    // lane masks
    // ones only on diagonal tiles (row lane == col lane)
    simd_t [W-1:0] mask_8;
    simd_t [W-1:0] mask_16;

    always_comb begin
        `IT_P(y, W) begin
            `IT_P(x, W) begin
                mask_8[y][x]  = ((y / `TILE_8) == (x / `TILE_8));
                mask_16[y][x] = ((y / `TILE_16) == (x / `TILE_16));
            end
        end
    end

    // and matrix, row i is a[i] against all of b
    simd_t [W-1:0] pp;

    always_comb begin
        `IT_P(i, W) begin
            `IT_P(j, W) begin
                logic y;
                logic flip;
                y = i_a[i] & i_b[j];
                if (op_dot8)       flip = bw_flip(i, j, `TILE_8);
                else if (op_dot16) flip = bw_flip(i, j, `TILE_16);
                else               flip = bw_flip(i, j, W); // plain 32x32
                if (i_op == MULT_OP_MULHU) flip = 1'b0; // the only unsigned case
                pp[i][j] = y ^ flip;
            end
        end
    end

    // row alignment per op
    always_comb begin
        `IT_P(i, W) begin
            logic [W_D-1:0] x;
            x = {{W{1'b0}}, pp[i]}; // unshifted for unused codes
            if (!op_simd) begin
                x = x << i; // full width, row weight 2^i
            end else if (op_dot16) begin
                x = {{W{1'b0}}, pp[i] & mask_16[i]};
                // lane-local col, then upper lane down onto lane 0 cols
                x = (x << (i % `TILE_16)) >> ((i / `TILE_16) * `TILE_16);
            end else if (op_dot8) begin
                x = {{W{1'b0}}, pp[i] & mask_8[i]};
                x = (x << (i % `TILE_8)) >> ((i / `TILE_8) * `TILE_8);
            end
            o_pp.rows[i] = x;
        end
    end

    // correction constant for modified bw
    logic [W_D-1:0] corr;

    always_comb begin
        corr = '0;
        if (!op_simd) begin
            corr[W]     = 1'b1; // 2^n
            corr[W_D-1] = 1'b1; // 2^(2n-1)
        end else if (op_dot16) begin
            corr[`TILE_16 + 1] = 1'b1; // bit 16 once per lane, two lanes
        end else if (op_dot8) begin
            corr[`TILE_8 + 2] = 1'b1; // bit 8 once per lane, four lanes
        end
        // lane top bits land above the kept result, dropped
    end

    assign o_pp.corr   = corr;
    assign o_pp.op     = i_op;
    assign o_pp.a      = i_a;
    assign o_pp.b_sign = i_b[W-1]; // mulhsu fix-up later

endmodule

`default_nettype wire

// File: logic/csa_tree_8.sv
`default_nettype none
`timescale 1ns/1ps

`include "mult_macros.svh"

module csa_tree_8 import mult_pkg::*; (
    input  simd_d_t [7:0] i_rows,
    output simd_d_t [1:0] o_rows // [0] sum, [1] carry
);

    localparam int unsigned W = `ARCH_WIDTH_D;

    // 3:2 counter over the whole row
    // [0] sum, [1] carry moved up one col
    function automatic logic [1:0][W-1:0] csa_3_2(
        input logic [W-1:0] x,
        input logic [W-1:0] y,
        input logic [W-1:0] z
    );
        logic [1:0][W-1:0] r;
        r[0] = x ^ y ^ z;
        r[1] = ((x & y) | (x & z) | (y & z)) << 1; // top carry out dropped, mod 2^64
        return r;
    endfunction

    logic [1:0][W-1:0] l1_a; // rows 0..2
    logic [1:0][W-1:0] l1_b; // rows 3..5
    logic [1:0][W-1:0] l2_a;
    logic [1:0][W-1:0] l2_b;
    logic [1:0][W-1:0] l3;
    logic [1:0][W-1:0] l4;

    // level 1, 8 -> 6
    assign l1_a = csa_3_2(i_rows[0], i_rows[1], i_rows[2]);
    assign l1_b = csa_3_2(i_rows[3], i_rows[4], i_rows[5]);

    // level 2, 6 -> 4 (rows 6 and 7 join here)
    assign l2_a = csa_3_2(l1_a[0], l1_a[1], l1_b[0]);
    assign l2_b = csa_3_2(l1_b[1], i_rows[6], i_rows[7]);

    // level 3, 4 -> 3
    assign l3 = csa_3_2(l2_a[0], l2_a[1], l2_b[0]);

    // level 4, 3 -> 2
    assign l4 = csa_3_2(l3[0], l3[1], l2_b[1]);

    assign o_rows[0] = l4[0];
    assign o_rows[1] = l4[1];

endmodule

`default_nettype wire

// File: logic/mult_reduce.sv
`default_nettype none
`timescale 1ns/1ps

`include "mult_macros.svh"

module mult_reduce import mult_pkg::*; (
    input  logic        clk,
    input  logic        i_arst_n,
    input  stage_ctrl_t i_ctrl, // exe/mem stage control
    pp_bus_if.dst       i_pp,
    sum_bus_if.src      o_sum
);

    localparam int unsigned N_TREE = `ARCH_WIDTH / 8; // 8 rows per tree

    // first level, four trees side by side
    simd_d_t [2*N_TREE-1:0] tree_o; // sum/carry pairs, tree t at [2t+1:2t]

    for (genvar t = 0; t < N_TREE; t++) begin : g_tree
        csa_tree_8 u_tree (
            .i_rows (i_pp.rows[8*t +: 8]),
            .o_rows (tree_o[2*t +: 2])
        );
    end

    // stage register
    simd_d_t [2*N_TREE-1:0] rows_q; // final tree inputs
    simd_d_t                corr_q;
    mult_op_t               op_q;
    simd_t                  a_q;
    logic                   b_sign_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rows_q   <= '0;
            corr_q   <= '0;
            op_q     <= MULT_OP_MUL;
            a_q      <= '0;
            b_sign_q <= 1'b0;
        end else if (i_ctrl.flush || i_ctrl.en) begin // else hold, stalled
            // flush loads the reset values
            rows_q   <= i_ctrl.flush ? '0 : tree_o;
            corr_q   <= i_ctrl.flush ? '0 : i_pp.corr;
            op_q     <= i_ctrl.flush ? MULT_OP_MUL : i_pp.op;
            a_q      <= i_ctrl.flush ? '0 : i_pp.a;
            b_sign_q <= i_ctrl.flush ? 1'b0 : i_pp.b_sign;
        end
    end

    // final tree and cpa, after the register
    simd_d_t [1:0] tree_f;

    csa_tree_8 u_tree_f (
        .i_rows (rows_q),
        .o_rows (tree_f)
    );

    assign o_sum.tree_sum = tree_f[0].d + tree_f[1].d; // sum + carry
    assign o_sum.corr     = corr_q;
    assign o_sum.op       = op_q;
    assign o_sum.a        = a_q;
    assign o_sum.b_sign   = b_sign_q;

endmodule

`default_nettype wire

// File: logic/mult_result_sel.sv
`default_nettype none
`timescale 1ns/1ps

`include "mult_macros.svh"

module mult_result_sel import mult_pkg::*; (
    sum_bus_if.dst i_sum,
    output simd_t  o_p
);

    localparam int unsigned DOT8_W   = `ARCH_WIDTH_H + 1;    // dot8 sum, 17 bits
    localparam int unsigned DOT8_PAD = `ARCH_WIDTH - DOT8_W; // sign pad, 15 bits

    simd_d_t mul_u;  // no correction, mulhu
    simd_d_t mul_s;  // corrected, all signed ops
    simd_t   mul_su; // high word of s x u

    assign mul_u = i_sum.tree_sum;
    assign mul_s = i_sum.tree_sum.d + i_sum.corr.d;

    // s x u = s x s + a * 2^32 when b msb is set
    assign mul_su = i_sum.b_sign ? (mul_s.w[1] + i_sum.a) : mul_s.w[1];

    always_comb begin
        case (i_sum.op)
            MULT_OP_MUL:    o_p = mul_s.w[0];
            MULT_OP_MULH:   o_p = mul_s.w[1];
            MULT_OP_MULHSU: o_p = mul_su;
            MULT_OP_MULHU:  o_p = mul_u.w[1];
            MULT_OP_DOT16:  o_p = mul_s.w[0]; // lanes already summed in the trees
            MULT_OP_DOT8: begin
                // sign-extend from bit 16
                o_p = {{DOT8_PAD{mul_s.d[DOT8_W-1]}}, mul_s.d[DOT8_W-1:0]};
            end
            default:        o_p = '0; // unused codes
        endcase
    end

endmodule

`default_nettype wire

// File: logic/simd_mult_top.sv
`default_nettype none
`timescale 1ns/1ps

module simd_mult_top import mult_pkg::*; (
    input  logic     clk,
    input  logic     i_arst_n,
    input  logic     i_stage_en,    // exe/mem enable
    input  logic     i_stage_flush, // exe/mem flush
    input  mult_op_t i_op,
    input  simd_t    i_a,
    input  simd_t    i_b,
    output simd_t    o_p            // one cycle after an enabled edge
);

    stage_ctrl_t stage_ctrl;

    assign stage_ctrl.en    = i_stage_en;
    assign stage_ctrl.flush = i_stage_flush;

    pp_bus_if  pp_bus  (); // pp gen -> reduce
    sum_bus_if sum_bus (); // reduce -> result select

    // pp matrix, corr and side data
    mult_pp_gen u_pp_gen (
        .i_op (i_op),
        .i_a  (i_a),
        .i_b  (i_b),
        .o_pp (pp_bus.src)
    );

    // trees, stage reg, final tree and cpa
    mult_reduce u_reduce (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_ctrl   (stage_ctrl),
        .i_pp     (pp_bus.dst),
        .o_sum    (sum_bus.src)
    );

    // correction and per-op select
    mult_result_sel u_result_sel (
        .i_sum (sum_bus.dst),
        .o_p   (o_p)
    );

endmodule

`default_nettype wire

// File: test/simd_mult_properties.sv
`default_nettype none
`timescale 1ns/1ps

`include "mult_macros.svh"

module simd_mult_properties import mult_pkg::*; (
    input logic     clk,
    input logic     i_arst_n,
    input logic     i_stage_en,
    input logic     i_stage_flush,
    input mult_op_t i_op,
    input simd_t    i_a,
    input simd_t    i_b,
    input simd_t    o_p
);

    localparam int unsigned W = `ARCH_WIDTH;

    int unsigned n_err = 0; // failed checks so far

    // expected result straight from the isa and dot product rules
    function automatic simd_t calc_expected(input mult_op_t op, input simd_t a, input simd_t b);
        logic [2*W-1:0]      p_ss;
        logic [2*W-1:0]      p_su;
        logic [2*W-1:0]      p_uu;
        logic signed [W-1:0] dot;
        p_ss = $signed({{W{a[W-1]}}, a}) * $signed({{W{b[W-1]}}, b});
        p_su = $signed({{W{a[W-1]}}, a}) * $signed({{W{1'b0}}, b}); // b as unsigned
        p_uu = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        dot  = '0;
        case (op)
            MULT_OP_MUL:    return p_ss[W-1:0];
            MULT_OP_MULH:   return p_ss[2*W-1:W];
            MULT_OP_MULHSU: return p_su[2*W-1:W];
            MULT_OP_MULHU:  return p_uu[2*W-1:W];
            MULT_OP_DOT16: begin
                `IT_P(k, 2) dot = dot + $signed(a[16*k +: 16]) * $signed(b[16*k +: 16]);
                return dot; // wraps mod 2^32
            end
            MULT_OP_DOT8: begin
                `IT_P(k, 4) dot = dot + $signed(a[8*k +: 8]) * $signed(b[8*k +: 8]);
                return {{15{dot[16]}}, dot[16:0]}; // 17 bit sum sign-extended
            end
            default:        return '0;
        endcase
    endfunction

    function automatic string test_name(input mult_op_t op);
        case (op)
            MULT_OP_MUL:    return "mul";
            MULT_OP_MULH:   return "mulh";
            MULT_OP_MULHSU: return "mulhsu";
            MULT_OP_MULHU:  return "mulhu";
            MULT_OP_DOT16:  return "dot16";
            MULT_OP_DOT8:   return "dot8";
            default:        return "unknown op";
        endcase
    endfunction

    // reference stage that mirrors en/flush of the exe/mem register
    simd_t    exp_p;
    mult_op_t exp_op;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            exp_p  <= '0;
            exp_op <= MULT_OP_MUL;
        end else if (i_stage_flush) begin // flush wins
            exp_p  <= '0;
            exp_op <= MULT_OP_MUL;
        end else if (i_stage_en) begin
            exp_p  <= calc_expected(i_op, i_a, i_b);
            exp_op <= i_op;
        end
    end

    a_reset_zero: assert property (@(posedge clk) !i_arst_n |=> o_p == '0)
        else begin
            $error("Error reset expected %h actual %h", 32'h0, $sampled(o_p));
            n_err++;
        end

    // flush with the enable low
    a_flush_zero: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_stage_flush && !i_stage_en) |=> o_p == '0)
        else begin
            $error("Error flush expected %h actual %h", 32'h0, $sampled(o_p));
            n_err++;
        end

    // flush must win when both are high
    a_flush_over_en: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_stage_flush && i_stage_en) |=> o_p == '0)
        else begin
            $error("Error flush_over_en expected %h actual %h", 32'h0, $sampled(o_p));
            n_err++;
        end

    a_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        (!i_stage_en && !i_stage_flush) |=> $stable(o_p))
        else begin
            $error("Error hold expected %h actual %h", $sampled(exp_p), $sampled(o_p));
            n_err++;
        end

    a_scalar: assert property (@(posedge clk) disable iff (!i_arst_n)
        !exp_op[2] |-> o_p == exp_p) // mul, mulh, mulhsu, mulhu
        else begin
            $error("Error %s expected %h actual %h", test_name($sampled(exp_op)),
                $sampled(exp_p), $sampled(o_p));
            n_err++;
        end

    a_dot16: assert property (@(posedge clk) disable iff (!i_arst_n)
        exp_op == MULT_OP_DOT16 |-> o_p == exp_p)
        else begin
            $error("Error dot16 expected %h actual %h", $sampled(exp_p), $sampled(o_p));
            n_err++;
        end

    a_dot8: assert property (@(posedge clk) disable iff (!i_arst_n)
        exp_op == MULT_OP_DOT8 |-> o_p == exp_p)
        else begin
            $error("Error dot8 expected %h actual %h", $sampled(exp_p), $sampled(o_p));
            n_err++;
        end

endmodule

bind simd_mult_top simd_mult_properties u_props (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_stage_en    (i_stage_en),
    .i_stage_flush (i_stage_flush),
    .i_op          (i_op),
    .i_a           (i_a),
    .i_b           (i_b),
    .o_p           (o_p)
);

`default_nettype wire

// File: test/simd_mult_tb.sv
`default_nettype none
`timescale 1ns/1ps

module simd_mult_tb import mult_pkg::*; ();

    localparam int unsigned RST_CYCLES  = 10;
    localparam int unsigned N_OPS       = 6;
    localparam int unsigned N_CORNER    = 7;
    localparam int unsigned N_DIRECT    = N_OPS * N_CORNER * N_CORNER; // every op x pair
    localparam int unsigned N_STALL     = 12; // stall and flush sequence
    localparam int unsigned N_RAND      = 200;
    localparam int unsigned N_DRAIN     = 3;
    localparam int unsigned N_STIM      = N_DIRECT + N_STALL + N_RAND + N_DRAIN;
    localparam int unsigned CYCLE_LIMIT = 2 * N_STIM + RST_CYCLES;

    localparam simd_t CORNERS [N_CORNER] = '{
        32'h0000_0000, // zero
        32'h0000_0001, // one
        32'hffff_ffff, // -1, also every lane -1
        32'h8000_0000, // most negative word
        32'h7fff_ffff, // most positive word
        32'h8000_8000, // 16 bit lane minimums
        32'h8080_8080  // 8 bit lane minimums
    };

    logic     clk;
    logic     i_arst_n;
    logic     i_stage_en;
    logic     i_stage_flush;
    mult_op_t i_op;
    simd_t    i_a;
    simd_t    i_b;
    simd_t    o_p;

    int unsigned cycle_cnt = 0;

    simd_mult_top dut (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_stage_en    (i_stage_en),
        .i_stage_flush (i_stage_flush),
        .i_op          (i_op),
        .i_a           (i_a),
        .i_b           (i_b),
        .o_p           (o_p)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    // runaway guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("TESTS FAILED");
            $fatal(1, "timeout, run went past %0d clock cycles", CYCLE_LIMIT);
        end
    end

    // checker raised a failure
    always @(negedge clk) begin
        if (dut.u_props.n_err != 0) begin
            $display("TESTS FAILED");
            $fatal(1, "an assertion in the checker failed");
        end
    end

    // one cycle of stimulus, set up on the falling edge
    task automatic drive_stage(input mult_op_t op, input simd_t a, input simd_t b,
                               input logic en, input logic flush);
        @(negedge clk);
        i_op          = op;
        i_a           = a;
        i_b           = b;
        i_stage_en    = en;
        i_stage_flush = flush;
    endtask

    task automatic run_corners();
        for (int o = 0; o < N_OPS; o++) begin
            for (int x = 0; x < N_CORNER; x++) begin
                for (int y = 0; y < N_CORNER; y++) begin
                    drive_stage(mult_op_t'(o), CORNERS[x], CORNERS[y], 1'b1, 1'b0);
                end
            end
        end
    endtask

    task automatic run_stall_flush();
        drive_stage(MULT_OP_MULH, 32'h1234_5678, 32'h9abc_def0, 1'b1, 1'b0);
        repeat (4) begin
            drive_stage(MULT_OP_DOT8, $urandom(), $urandom(), 1'b0, 1'b0); // inputs move
        end
        drive_stage(MULT_OP_MUL, 32'hffff_ffff, 32'h0000_0007, 1'b1, 1'b1); // both high
        drive_stage(MULT_OP_DOT16, 32'h8000_7fff, 32'h8000_7fff, 1'b1, 1'b0);
        drive_stage(MULT_OP_MUL, 32'h0000_0003, 32'h0000_0005, 1'b0, 1'b1); // flush only
        repeat (2) begin
            drive_stage(MULT_OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0); // zero held
        end
        drive_stage(MULT_OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 1'b1, 1'b0);
        drive_stage(MULT_OP_MULHSU, 32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b0);
    endtask

    task automatic run_random();
        mult_op_t op;
        simd_t    a;
        simd_t    b;
        logic     en;
        logic     flush;
        for (int n = 0; n < N_RAND; n++) begin
            op    = mult_op_t'($urandom_range(N_OPS - 1, 0));
            // corner operands now and then
            a     = ($urandom_range(3, 0) == 0) ? CORNERS[$urandom_range(N_CORNER - 1, 0)]
                                                : simd_t'($urandom());
            b     = ($urandom_range(3, 0) == 0) ? CORNERS[$urandom_range(N_CORNER - 1, 0)]
                                                : simd_t'($urandom());
            en    = ($urandom_range(3, 0) != 0); // mostly enabled
            flush = ($urandom_range(9, 0) == 0);
            drive_stage(op, a, b, en, flush);
        end
    endtask

    initial begin
        void'($urandom(32'h2eda));
        i_arst_n      = 1'b0;
        i_stage_en    = 1'b0;
        i_stage_flush = 1'b0;
        i_op          = MULT_OP_MUL;
        i_a           = '0;
        i_b           = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;

        run_corners();
        run_stall_flush();
        run_random();

        // idle, let the last checks fire
        drive_stage(MULT_OP_MUL, '0, '0, 1'b0, 1'b0);
        repeat (N_DRAIN - 1) @(posedge clk);
        @(negedge clk);

        if (dut.u_props.n_err == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "%0d checker assertions failed", dut.u_props.n_err);
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
logic/mult_pkg.sv
logic/mult_if.sv
logic/mult_pp_gen.sv
logic/csa_tree_8.sv
logic/mult_reduce.sv
logic/mult_result_sel.sv
logic/simd_mult_top.sv
test/simd_mult_properties.sv
test/simd_mult_tb.sv

// File: Bender.yml
package:
  name: simd_mult

export_include_dirs:
  - include

sources:
  - logic/mult_pkg.sv
  - logic/mult_if.sv
  - logic/mult_pp_gen.sv
  - logic/csa_tree_8.sv
  - logic/mult_reduce.sv
  - logic/mult_result_sel.sv
  - logic/simd_mult_top.sv
  - target: test
    files:
      - test/simd_mult_properties.sv
      - test/simd_mult_tb.sv
